// File: decodeStage.sv
/* fetch and decode stage */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module decodeStage import procPkg::*; (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          imemLoadEn,
   input  wire [`PROC_DATA_WIDTH-1:0]   imemLoadAddr,
   input  wire [`PROC_DATA_WIDTH-1:0]   imemLoadData,
   input  wire                          redirect,
   input  wire [`PROC_DATA_WIDTH-1:0]   redirectTarget,
   input  wire                          wbEn,
   input  wire [`PROC_REG_ADDR_W-1:0]   wbAddr,
   input  wire [`PROC_DATA_WIDTH-1:0]   wbData,
   decodeToExecute.decode               dx
);

   localparam int imemAddrW = $clog2(`PROC_IMEM_DEPTH);

   logic [`PROC_DATA_WIDTH-1:0] imem [`PROC_IMEM_DEPTH];
   logic [`PROC_DATA_WIDTH-1:0] regs [`PROC_REG_COUNT];
   logic [`PROC_DATA_WIDTH-1:0] pc;
   logic [`PROC_DATA_WIDTH-1:0] pcPlusTwo;
   logic                        stopped;   // HALT seen, fetch frozen
   instrT                       instr;

   logic                        regWriteD;
   logic                        memReadD;
   logic                        memWriteD;
   logic                        isBranchD;
   logic                        branchOnZeroD;
   logic                        useImmD;
   logic                        illegalD;
   logic                        haltD;
   aluOpT                       aluOpD;
   logic [`PROC_REG_ADDR_W-1:0] destAddrD;
   logic [`PROC_DATA_WIDTH-1:0] rsValD;
   logic [`PROC_DATA_WIDTH-1:0] rtValD;
   logic [`PROC_DATA_WIDTH-1:0] immD;

   // program load, only while reset is held
   always_ff @(posedge clk) begin
      if (reset && imemLoadEn)
         imem[imemLoadAddr[imemAddrW:1]] <= imemLoadData;
   end

   assign instr     = imem[pc[imemAddrW:1]];
   assign pcPlusTwo = pc + `PROC_PC_STEP;
   assign immD      = {{(`PROC_DATA_WIDTH - `PROC_IMM_W){instr.iView.imm5[`PROC_IMM_W-1]}},
                       instr.iView.imm5};

   // r0 is hardwired, a same-cycle writeback wins over the array
   function automatic logic [`PROC_DATA_WIDTH-1:0] readPort(
      input logic [`PROC_REG_ADDR_W-1:0] addr
   );
      if (addr == '0)
         return '0;
      if (wbEn && wbAddr == addr)
         return wbData;
      return regs[addr];
   endfunction

   always_comb begin
      regWriteD     = 1'b0;
      memReadD      = 1'b0;
      memWriteD     = 1'b0;
      isBranchD     = 1'b0;
      branchOnZeroD = 1'b0;
      useImmD       = 1'b0;
      illegalD      = 1'b0;
      haltD         = 1'b0;
      aluOpD        = aluAdd;
      destAddrD     = instr.iView.rd;
      case (instr.rView.opcode)
         opHalt:  haltD = 1'b1;
         opNop:   ;
         opAddi: begin
            regWriteD = 1'b1;
            useImmD   = 1'b1;
         end
         opSt:    memWriteD = 1'b1;   // address formed in execute
         opLd: begin
            memReadD  = 1'b1;
            regWriteD = 1'b1;
         end
         opBeqz: begin
            isBranchD     = 1'b1;
            branchOnZeroD = 1'b1;
         end
         opBnez:  isBranchD = 1'b1;
         opRtype: begin
            regWriteD = 1'b1;
            aluOpD    = aluOpT'(instr.rView.func);
            destAddrD = instr.rView.rd;
         end
         default: illegalD = 1'b1;
      endcase
      // writes to r0 are dropped here
      if (destAddrD == '0)
         regWriteD = 1'b0;
      rsValD = readPort(instr.rView.rs);
      rtValD = readPort(instr.rView.rt);
   end

   always_ff @(posedge clk) begin
      if (wbEn && wbAddr != '0)
         regs[wbAddr] <= wbData;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= '0;
         stopped  <= 1'b0;
         dx.valid <= 1'b0;
      end else begin
         if (redirect)
            pc <= redirectTarget;
         else if (!(haltD || stopped))
            pc <= pcPlusTwo;
         stopped  <= stopped || (haltD && !redirect);
         dx.valid <= !(redirect || stopped);   // squashed slot or frozen
      end
   end

   always_ff @(posedge clk) begin
      dx.opcode       <= instr.rView.opcode;
      dx.aluOp        <= aluOpD;
      dx.regWrite     <= regWriteD;
      dx.memRead      <= memReadD;
      dx.memWrite     <= memWriteD;
      dx.isBranch     <= isBranchD;
      dx.branchOnZero <= branchOnZeroD;
      dx.useImm       <= useImmD;
      dx.illegal      <= illegalD;
      dx.halt         <= haltD;
      dx.rsAddr       <= instr.rView.rs;
      dx.rtAddr       <= instr.rView.rt;
      dx.destAddr     <= destAddrD;
      dx.rsVal        <= rsValD;
      dx.rtVal        <= rtValD;
      dx.imm          <= immD;
      dx.pcPlusTwo    <= pcPlusTwo;
   end

   loadInReset: assert property (@(posedge clk) imemLoadEn |-> reset)
      else $error("instruction memory load outside reset");

endmodule

`default_nettype wire

// File: executeStage.sv
/* execute stage */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module executeStage import procPkg::*; (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          wbEn,
   input  wire [`PROC_REG_ADDR_W-1:0]   wbAddr,
   input  wire [`PROC_DATA_WIDTH-1:0]   wbData,
   decodeToExecute.execute              dx,
   executeToResult.execute              xr,
   output logic                         redirect,
   output logic [`PROC_DATA_WIDTH-1:0]  redirectTarget,
   output logic                         err
);

   logic [`PROC_DATA_WIDTH-1:0] rsFwd;
   logic [`PROC_DATA_WIDTH-1:0] rtFwd;
   logic [`PROC_DATA_WIDTH-1:0] aluB;
   logic [`PROC_DATA_WIDTH-1:0] aluOut;
   logic [`PROC_DATA_WIDTH-1:0] addrSum;
   logic [`PROC_DATA_WIDTH-1:0] aluResult;
   logic                        isMemOp;

   // the slot in result is one ahead, older values are already in the regfile
   function automatic logic [`PROC_DATA_WIDTH-1:0] forward(
      input logic [`PROC_REG_ADDR_W-1:0] addr,
      input logic [`PROC_DATA_WIDTH-1:0] regVal
   );
      if (wbEn && addr != '0 && wbAddr == addr)
         return wbData;
      return regVal;
   endfunction

   always_comb begin
      rsFwd = forward(dx.rsAddr, dx.rsVal);
      rtFwd = forward(dx.rtAddr, dx.rtVal);
   end

   assign aluB = dx.useImm ? dx.imm : rtFwd;

   always_comb begin
      case (dx.aluOp)
         aluAdd:  aluOut = rsFwd + aluB;
         aluSub:  aluOut = rsFwd - aluB;
         aluXor:  aluOut = rsFwd ^ aluB;
         aluAnd:  aluOut = rsFwd & aluB;
         default: aluOut = rsFwd + aluB;
      endcase
   end

   // LD and ST go through the address adder
   assign isMemOp   = (dx.opcode == opLd) || (dx.opcode == opSt);
   assign addrSum   = rsFwd + dx.imm;
   assign aluResult = isMemOp ? addrSum : aluOut;

   // taken when the zero test agrees with the branch kind
   assign redirect       = dx.valid && dx.isBranch && ((rsFwd == '0) == dx.branchOnZero);
   assign redirectTarget = dx.pcPlusTwo + dx.imm;

   always_ff @(posedge clk) begin
      if (reset) begin
         err      <= 1'b0;
         xr.valid <= 1'b0;
      end else begin
         if (dx.valid && dx.illegal)
            err <= 1'b1;                       // sticky until reset
         xr.valid <= dx.valid && !dx.illegal;   // illegal slot dies here
      end
   end

   always_ff @(posedge clk) begin
      xr.regWrite  <= dx.regWrite;
      xr.memRead   <= dx.memRead;
      xr.memWrite  <= dx.memWrite;
      xr.halt      <= dx.halt;
      xr.destAddr  <= dx.destAddr;
      xr.aluResult <= aluResult;
      xr.storeData <= rtFwd;
   end

   // the squashed slot behind a taken branch cannot branch again
   singleRedirect: assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
      else $error("redirect high two cycles in a row");

   errSticky: assert property (@(posedge clk) err && !reset |=> err)
      else $error("err fell without reset");

endmodule

`default_nettype wire

// File: proc.sv
/* three stage processor top */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module proc (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          imemLoadEn,
   input  wire [`PROC_DATA_WIDTH-1:0]   imemLoadAddr,
   input  wire [`PROC_DATA_WIDTH-1:0]   imemLoadData,
   output logic                         wbEn,
   output logic [`PROC_REG_ADDR_W-1:0]  wbAddr,
   output logic [`PROC_DATA_WIDTH-1:0]  wbData,
   output logic                         halted,
   output logic                         err
);

   logic                        redirect;
   logic [`PROC_DATA_WIDTH-1:0] redirectTarget;

   decodeToExecute dxBus ();
   executeToResult xrBus ();

   decodeStage decode0 (
      .clk            (clk),
      .reset          (reset),
      .imemLoadEn     (imemLoadEn),
      .imemLoadAddr   (imemLoadAddr),
      .imemLoadData   (imemLoadData),
      .redirect       (redirect),
      .redirectTarget (redirectTarget),
      .wbEn           (wbEn),
      .wbAddr         (wbAddr),
      .wbData         (wbData),
      .dx             (dxBus.decode)
   );

   // writeback also feeds the forwarding path
   executeStage execute0 (
      .clk            (clk),
      .reset          (reset),
      .wbEn           (wbEn),
      .wbAddr         (wbAddr),
      .wbData         (wbData),
      .dx             (dxBus.execute),
      .xr             (xrBus.execute),
      .redirect       (redirect),
      .redirectTarget (redirectTarget),
      .err            (err)
   );

   resultStage result0 (
      .clk    (clk),
      .reset  (reset),
      .xr     (xrBus.result),
      .wbEn   (wbEn),
      .wbAddr (wbAddr),
      .wbData (wbData),
      .halted (halted)
   );

endmodule

`default_nettype wire

// File: procIf.sv
/* pipeline stage buses */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

// decode stage register, valid low means bubble
interface decodeToExecute import procPkg::*; ();
   logic                        valid;
   opcodeT                      opcode;
   aluOpT                       aluOp;
   logic                        regWrite;
   logic                        memRead;
   logic                        memWrite;
   logic                        isBranch;
   logic                        branchOnZero;  // BEQZ when high
   logic                        useImm;
   logic                        illegal;
   logic                        halt;
   logic [`PROC_REG_ADDR_W-1:0] rsAddr;
   logic [`PROC_REG_ADDR_W-1:0] rtAddr;
   logic [`PROC_REG_ADDR_W-1:0] destAddr;
   logic [`PROC_DATA_WIDTH-1:0] rsVal;
   logic [`PROC_DATA_WIDTH-1:0] rtVal;
   logic [`PROC_DATA_WIDTH-1:0] imm;
   logic [`PROC_DATA_WIDTH-1:0] pcPlusTwo;

   modport decode (output valid, opcode, aluOp, regWrite, memRead, memWrite, isBranch,
      branchOnZero, useImm, illegal, halt, rsAddr, rtAddr, destAddr, rsVal, rtVal, imm,
      pcPlusTwo);
   modport execute (input valid, opcode, aluOp, regWrite, memRead, memWrite, isBranch,
      branchOnZero, useImm, illegal, halt, rsAddr, rtAddr, destAddr, rsVal, rtVal, imm,
      pcPlusTwo);
endinterface

// execute stage register
interface executeToResult ();
   logic                        valid;
   logic                        regWrite;
   logic                        memRead;
   logic                        memWrite;
   logic                        halt;
   logic [`PROC_REG_ADDR_W-1:0] destAddr;
   logic [`PROC_DATA_WIDTH-1:0] aluResult;  // memory address for LD and ST
   logic [`PROC_DATA_WIDTH-1:0] storeData;

   modport execute (output valid, regWrite, memRead, memWrite, halt, destAddr, aluResult,
      storeData);
   modport result (input valid, regWrite, memRead, memWrite, halt, destAddr, aluResult,
      storeData);
endinterface

`default_nettype wire

// File: procPkg.sv
/* processor types */
`default_nettype none
`include "proc_defs.svh"

package procPkg;

   // opcode lives in bits 15..11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opAddi  = 5'b01000,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opRtype = 5'b11011
   } opcodeT;

   // encoding matches the R-type func field
   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluXor = 2'b10,
      aluAnd = 2'b11
   } aluOpT;

   typedef struct packed {
      opcodeT                      opcode;
      logic [`PROC_REG_ADDR_W-1:0] rs;
      logic [`PROC_REG_ADDR_W-1:0] rt;    // also the store data register
      logic [`PROC_REG_ADDR_W-1:0] rd;
      logic [1:0]                  func;
   } rViewT;

   typedef struct packed {
      opcodeT                      opcode;
      logic [`PROC_REG_ADDR_W-1:0] rs;
      logic [`PROC_REG_ADDR_W-1:0] rd;
      logic [`PROC_IMM_W-1:0]      imm5;  // sign extended in decode
   } iViewT;

   // one instruction word, two ways of reading it
   typedef union packed {
      rViewT rView;
      iViewT iView;
   } instrT;

endpackage

`default_nettype wire

// File: procTb.sv
/* processor testbench */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module procTb import procPkg::*; ();

   localparam int numProgs = 3;
   localparam int progLen  = 16;     // one load per reset cycle
   localparam int haltTimeout = 500;

   logic                        clk;
   logic                        reset;
   logic                        imemLoadEn;
   logic [`PROC_DATA_WIDTH-1:0] imemLoadAddr;
   logic [`PROC_DATA_WIDTH-1:0] imemLoadData;
   logic                        wbEn;
   logic [`PROC_REG_ADDR_W-1:0] wbAddr;
   logic [`PROC_DATA_WIDTH-1:0] wbData;
   logic                        halted;
   logic                        err;

   // program words and the writebacks the ISA predicts for them
   logic [15:0] progTable [numProgs][progLen];
   logic [2:0]  expAddr [numProgs][progLen];
   logic [15:0] expData [numProgs][progLen];
   int          expCount [numProgs];
   logic        expErr [numProgs];

   int valueErrors;
   int otherErrors;

   proc proc_inst (
      .clk          (clk),
      .reset        (reset),
      .imemLoadEn   (imemLoadEn),
      .imemLoadAddr (imemLoadAddr),
      .imemLoadData (imemLoadData),
      .wbEn         (wbEn),
      .wbAddr       (wbAddr),
      .wbData       (wbData),
      .halted       (halted),
      .err          (err)
   );

   always #2 clk = ~clk;

   function automatic logic [15:0] encodeImm(opcodeT op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic logic [15:0] encodeReg(int rs, int rt, int rd, aluOpT func);
      return {opRtype, 3'(rs), 3'(rt), 3'(rd), func};
   endfunction

   task automatic buildPrograms();
      for (int p = 0; p < numProgs; p++)
         for (int i = 0; i < progLen; i++)
            progTable[p][i] = 16'h0000;   // HALT padding
      // ALU funcs and forwarding one and two apart
      progTable[0][0] = encodeImm(opAddi, 0, 1, 5);
      progTable[0][1] = encodeImm(opAddi, 0, 2, 3);
      progTable[0][2] = encodeReg(1, 2, 3, aluAdd);
      progTable[0][3] = encodeReg(3, 2, 4, aluSub);
      progTable[0][4] = encodeReg(1, 2, 5, aluXor);
      progTable[0][5] = encodeReg(5, 4, 6, aluAnd);
      progTable[0][6] = encodeImm(opAddi, 6, 7, -1);
      progTable[0][7] = encodeReg(0, 7, 1, aluSub);
      progTable[0][9] = encodeImm(opAddi, 0, 2, 15);   // sits behind HALT and never runs
      // illegal word between two dependent instructions
      progTable[1][0] = encodeImm(opAddi, 0, 1, 6);
      progTable[1][1] = {5'b11111, 3'd1, 3'd4, 5'd13};   // nonzero rd field must not write
      progTable[1][2] = encodeImm(opAddi, 1, 2, 2);
      progTable[1][3] = encodeReg(2, 1, 3, aluAdd);
      // store, load, then taken and not-taken branches
      progTable[2][0]  = encodeImm(opAddi, 0, 1, 9);
      progTable[2][1]  = encodeImm(opAddi, 0, 2, 4);
      progTable[2][2]  = encodeImm(opSt, 2, 1, 2);
      progTable[2][3]  = encodeImm(opLd, 2, 3, 2);
      progTable[2][4]  = encodeImm(opAddi, 3, 4, 1);
      progTable[2][5]  = encodeImm(opBeqz, 0, 0, 2);
      progTable[2][6]  = encodeImm(opAddi, 0, 5, 1);
      progTable[2][7]  = encodeImm(opBnez, 1, 0, 2);
      progTable[2][8]  = encodeImm(opAddi, 0, 5, 2);
      progTable[2][9]  = encodeImm(opBeqz, 1, 0, 2);
      progTable[2][10] = encodeImm(opAddi, 0, 5, 3);
      progTable[2][11] = encodeImm(opBnez, 0, 0, 2);
      progTable[2][12] = encodeImm(opAddi, 5, 6, 4);
      progTable[2][14] = encodeImm(opAddi, 0, 7, 1);
   endtask

   // instruction-at-a-time ISA model that fills the expected tables
   task automatic modelProgram(input int p);
      logic [15:0] regFile [8];
      logic [15:0] memory [logic [15:0]];
      logic [15:0] w;
      logic [15:0] imm;
      logic [15:0] rsVal;
      logic [15:0] rtVal;
      logic [15:0] target;
      logic [15:0] wrVal;
      logic [2:0]  wrIdx;
      logic [4:0]  op;
      bit          wr;
      bit          stop;
      int          pcIdx;
      int          steps;
      int          n;
      for (int r = 0; r < 8; r++)
         regFile[r] = '0;
      pcIdx = 0;
      steps = 0;
      n = 0;
      stop = 1'b0;
      expErr[p] = 1'b0;
      while (!stop && pcIdx >= 0 && pcIdx < progLen && steps < 200) begin
         w = progTable[p][pcIdx];
         op = w[15:11];
         imm = {{11{w[4]}}, w[4:0]};
         rsVal = regFile[w[10:8]];
         rtVal = regFile[w[7:5]];
         target = 16'(2 * (pcIdx + 1)) + imm;   // pcPlusTwo + imm
         wr = 1'b0;
         wrIdx = w[7:5];
         wrVal = '0;
         pcIdx++;
         steps++;
         case (op)
            opHalt: stop = 1'b1;
            opNop: ;
            opAddi: begin
               wr = 1'b1;
               wrVal = rsVal + imm;
            end
            opSt: memory[rsVal + imm] = rtVal;
            opLd: begin
               wr = 1'b1;
               wrVal = memory[rsVal + imm];
            end
            opBeqz: if (rsVal == '0) pcIdx = int'(target[15:1]);
            opBnez: if (rsVal != '0) pcIdx = int'(target[15:1]);
            opRtype: begin
               wr = 1'b1;
               wrIdx = w[4:2];
               case (w[1:0])
                  2'b00: wrVal = rsVal + rtVal;
                  2'b01: wrVal = rsVal - rtVal;
                  2'b10: wrVal = rsVal ^ rtVal;
                  2'b11: wrVal = rsVal & rtVal;
               endcase
            end
            default: expErr[p] = 1'b1;   // no other effect
         endcase
         if (wr && wrIdx != 3'd0) begin
            regFile[wrIdx] = wrVal;
            expAddr[p][n] = wrIdx;
            expData[p][n] = wrVal;
            n++;
         end
      end
      expCount[p] = n;
   endtask

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      assert (got === exp) else begin
         valueErrors++;
         $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   // reset high for 16 sampled edges with one program word loaded on each
   task automatic resetAndLoad(input int p);
      for (int i = 0; i < progLen; i++) begin
         @(posedge clk);
         reset        <= 1'b1;
         imemLoadEn   <= 1'b1;
         imemLoadAddr <= 16'(2 * i);
         imemLoadData <= progTable[p][i];
      end
      @(posedge clk);
      reset      <= 1'b0;
      imemLoadEn <= 1'b0;
   endtask

   task automatic runProgram(input int p);
      int idx;
      int cyc;
      bit done;
      idx = 0;
      done = 1'b0;
      resetAndLoad(p);
      @(negedge clk);
      checkValue("wbEn", 16'(wbEn), 16'd0);
      checkValue("halted", 16'(halted), 16'd0);
      checkValue("err", 16'(err), 16'd0);
      for (cyc = 0; cyc < haltTimeout && !done; cyc++) begin
         if (wbEn === 1'b1) begin
            assert (idx < expCount[p]) else begin
               otherErrors++;
               $display("%0t: program %0d wrote r%0d beyond its expected writebacks",
                        $time, p, wbAddr);
            end
            if (idx < expCount[p]) begin
               checkValue("wbAddr", 16'(wbAddr), 16'(expAddr[p][idx]));
               checkValue("wbData", wbData, expData[p][idx]);
            end
            idx++;
         end
         if (halted === 1'b1)
            done = 1'b1;
         else
            @(negedge clk);
      end
      if (!done) begin
         otherErrors++;
         $display("program %0d: halted did not rise within %0d cycles", p, haltTimeout);
      end else begin
         for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            checkValue("wbEn", 16'(wbEn), 16'd0);   // nothing after HALT
            checkValue("halted", 16'(halted), 16'd1);
         end
         assert (idx == expCount[p]) else begin
            otherErrors++;
            $display("program %0d retired %0d writebacks instead of %0d",
                     p, idx, expCount[p]);
         end
         checkValue("err", 16'(err), 16'(expErr[p]));
      end
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      imemLoadEn   = 1'b0;
      imemLoadAddr = '0;
      imemLoadData = '0;
      valueErrors  = 0;
      otherErrors  = 0;
      buildPrograms();
      for (int p = 0; p < numProgs; p++)
         modelProgram(p);
      for (int p = 0; p < numProgs; p++)
         runProgram(p);
      $display("checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: proc_defs.svh
/* processor size parameters */

`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// datapath and instruction word
`define PROC_DATA_WIDTH 16

// register file, r0 reads zero
`define PROC_REG_ADDR_W 3
`define PROC_REG_COUNT  8

// words of memory, both indexed by byte address bits above bit 0
`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64

// pc is a byte address, one instruction is two bytes
`define PROC_PC_STEP 16'd2

// width of the imm5 field before sign extension
`define PROC_IMM_W 5

`endif

// File: resultStage.sv
/* memory and writeback stage */
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module resultStage (
   input  wire                          clk,
   input  wire                          reset,
   executeToResult.result               xr,
   output logic                         wbEn,
   output logic [`PROC_REG_ADDR_W-1:0]  wbAddr,
   output logic [`PROC_DATA_WIDTH-1:0]  wbData,
   output logic                         halted
);

   localparam int dmemAddrW = $clog2(`PROC_DMEM_DEPTH);

   logic [`PROC_DATA_WIDTH-1:0] dmem [`PROC_DMEM_DEPTH];
   logic [dmemAddrW-1:0]        dmemIdx;
   logic [`PROC_DATA_WIDTH-1:0] loadData;
   logic                        haltSeen;

   assign dmemIdx  = xr.aluResult[dmemAddrW:1];   // word index from byte address
   assign loadData = dmem[dmemIdx];

   always_ff @(posedge clk) begin
      if (xr.valid && xr.memWrite)
         dmem[dmemIdx] <= xr.storeData;
   end

   // regfile write lands at the end of this cycle
   assign wbEn   = xr.valid && xr.regWrite;
   assign wbAddr = xr.destAddr;
   assign wbData = xr.memRead ? loadData : xr.aluResult;

   always_ff @(posedge clk) begin
      if (reset)
         haltSeen <= 1'b0;
      else if (xr.valid && xr.halt)
         haltSeen <= 1'b1;
   end

   // high from the cycle HALT arrives
   assign halted = haltSeen || (xr.valid && xr.halt);

   // decode drops r0 destinations, nothing downstream should revive them
   noR0Write: assert property (@(posedge clk) disable iff (reset) wbEn |-> wbAddr != '0)
      else $error("writeback to r0");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
# compile and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module procTb -o procSim \
   && ./obj_dir/procSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" \
   || { echo "result: fail"; exit 1; }

// File: verilog.f
+incdir+.
procPkg.sv
procIf.sv
decodeStage.sv
executeStage.sv
resultStage.sv
proc.sv
procTb.sv
